/* common/line_mirror_config.svh */
`ifndef LINE_MIRROR_CONFIG_SVH
`define LINE_MIRROR_CONFIG_SVH

// Pixel width in bits. The byte-order logic assumes four bytes per pixel.
`define LM_PIX_W 32

// Buffer address width. Each half holds up to 2**LM_ADDR_W pixels.
`define LM_ADDR_W 6

`endif

/* common/line_mirror_pkg.sv */
`include "line_mirror_config.svh"

package line_mirror_pkg;

    // One pixel on the stream with its end-of-line marker.
    typedef struct packed {
        logic [`LM_PIX_W-1:0] data;
        logic                 last;
    } pixel_beat_t;

    typedef enum logic [1:0] {
        ORDER_KEEP   = 2'd0,
        ORDER_SWAP16 = 2'd1,
        ORDER_SWAP32 = 2'd2
    } byte_order_e;

    // State of one half of the ping-pong line buffer.
    typedef enum logic [1:0] {
        BUF_EMPTY    = 2'd0,
        BUF_FILLING  = 2'd1,
        BUF_FULL     = 2'd2,
        BUF_DRAINING = 2'd3
    } buf_state_e;

endpackage

/* verilog/pixel_ingress.sv */
`timescale 1ns/1ps
`include "line_mirror_config.svh"

module pixel_ingress (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [`LM_PIX_W-1:0]        pix_in,
    input  logic                        pix_in_en,
    input  logic [`LM_ADDR_W:0]         width,
    input  line_mirror_pkg::byte_order_e order,
    output line_mirror_pkg::pixel_beat_t in_beat,
    output logic                        in_en
);

    logic [`LM_ADDR_W-1:0] col;
    logic [`LM_ADDR_W:0]   width_q;
    logic [`LM_ADDR_W:0]   line_width;
    logic                  is_last;
    logic [`LM_PIX_W-1:0]  pix_ordered;

    always_comb begin
        case (order)
            line_mirror_pkg::ORDER_SWAP16:
                pix_ordered = {pix_in[23:16], pix_in[31:24], pix_in[7:0], pix_in[15:8]};
            line_mirror_pkg::ORDER_SWAP32:
                pix_ordered = {pix_in[7:0], pix_in[15:8], pix_in[23:16], pix_in[31:24]};
            default:
                pix_ordered = pix_in;
        endcase
    end

    // The width input is only trusted at the first pixel of a line.
    assign line_width = (col == '0) ? width : width_q;
    assign is_last    = ({1'b0, col} == line_width - 1'b1);

    always_ff @(posedge clk) begin
        if (rst) begin
            in_en   <= 1'b0;
            col     <= '0;
            width_q <= '0;
        end else begin
            in_en <= pix_in_en;
            if (pix_in_en) begin
                if (col == '0) begin
                    width_q <= width;
                end
                if (is_last) begin
                    col <= '0;
                end else begin
                    col <= col + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pix_in_en) begin
            in_beat.data <= pix_ordered;
            in_beat.last <= is_last;
        end
    end

endmodule

/* line_reverse/line_reverse.sv */
`timescale 1ns/1ps
`include "line_mirror_config.svh"

module line_reverse (
    input  logic                         clk,
    input  logic                         rst,
    input  line_mirror_pkg::pixel_beat_t in_beat,
    input  logic                         in_en,
    output line_mirror_pkg::pixel_beat_t rev_beat,
    output logic                         rev_valid,
    input  logic                         rev_ready,
    output logic                         overflow
);

    localparam int DEPTH = 1 << `LM_ADDR_W;

    logic [`LM_PIX_W-1:0] mem0 [DEPTH];
    logic [`LM_PIX_W-1:0] mem1 [DEPTH];
    logic [`LM_ADDR_W:0]  len  [2];

    line_mirror_pkg::buf_state_e state [2];

    logic                  wr_half;
    logic                  rd_half;
    logic [`LM_ADDR_W-1:0] wr_ptr;
    logic [`LM_ADDR_W-1:0] rd_ptr;
    logic                  dropping;
    logic                  wr_accept;
    logic                  rd_start;
    logic                  rd_xfer;
    logic [`LM_ADDR_W:0]   len_m1;
    logic [`LM_ADDR_W-1:0] rd_addr;

    // A pixel is stored only while its half is free or already taking this line.
    assign wr_accept = in_en && !dropping &&
                       (state[wr_half] == line_mirror_pkg::BUF_EMPTY ||
                        state[wr_half] == line_mirror_pkg::BUF_FILLING);

    assign rd_start = (state[rd_half] == line_mirror_pkg::BUF_FULL);
    assign rd_xfer  = rev_valid && rev_ready;
    assign len_m1   = len[rd_half] - 1'b1;
    assign rd_addr  = rd_start ? len_m1[`LM_ADDR_W-1:0] : rd_ptr - 1'b1;

    always_ff @(posedge clk) begin
        if (rst) begin
            state[0]  <= line_mirror_pkg::BUF_EMPTY;
            state[1]  <= line_mirror_pkg::BUF_EMPTY;
            wr_half   <= 1'b0;
            rd_half   <= 1'b0;
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            dropping  <= 1'b0;
            overflow  <= 1'b0;
            rev_valid <= 1'b0;
        end else begin
            if (wr_accept) begin
                if (in_beat.last) begin
                    state[wr_half] <= line_mirror_pkg::BUF_FULL;
                    wr_half        <= ~wr_half;
                    wr_ptr         <= '0;
                end else begin
                    state[wr_half] <= line_mirror_pkg::BUF_FILLING;
                    wr_ptr         <= wr_ptr + 1'b1;
                end
            end else if (in_en && dropping) begin
                if (in_beat.last) begin
                    dropping <= 1'b0;
                end
            end else if (in_en) begin
                // Line start with no empty half, so the whole line is thrown away.
                overflow <= 1'b1;
                dropping <= !in_beat.last;
            end

            // Read and write never move the same half in one cycle.
            if (rd_start) begin
                state[rd_half] <= line_mirror_pkg::BUF_DRAINING;
                rev_valid      <= 1'b1;
                rd_ptr         <= len_m1[`LM_ADDR_W-1:0];
            end else if (rd_xfer) begin
                if (rev_beat.last) begin
                    state[rd_half] <= line_mirror_pkg::BUF_EMPTY;
                    rev_valid      <= 1'b0;
                    rd_half        <= ~rd_half;
                end else begin
                    rd_ptr <= rd_ptr - 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_accept) begin
            if (wr_half) begin
                mem1[wr_ptr] <= in_beat.data;
            end else begin
                mem0[wr_ptr] <= in_beat.data;
            end
            if (in_beat.last) begin
                len[wr_half] <= {1'b0, wr_ptr} + 1'b1;
            end
        end
    end

    // Output register is loaded at line start and after each transfer.
    always_ff @(posedge clk) begin
        if (rd_start || (rd_xfer && !rev_beat.last)) begin
            rev_beat.data <= rd_half ? mem1[rd_addr] : mem0[rd_addr];
            rev_beat.last <= (rd_addr == '0);
        end
    end

endmodule

/* verilog/pixel_egress.sv */
`timescale 1ns/1ps
`include "line_mirror_config.svh"

module pixel_egress (
    input  logic                         clk,
    input  logic                         rst,
    input  line_mirror_pkg::pixel_beat_t rev_beat,
    input  logic                         rev_valid,
    output logic                         rev_ready,
    output line_mirror_pkg::pixel_beat_t out_beat,
    output logic                         out_valid,
    input  logic                         out_ready,
    output logic [15:0]                  line_count
);

    line_mirror_pkg::pixel_beat_t skid_beat;
    line_mirror_pkg::pixel_beat_t head_n;
    line_mirror_pkg::pixel_beat_t skid_n;
    logic                         skid_valid;
    logic                         head_v_n;
    logic                         skid_v_n;
    logic                         in_xfer;
    logic                         out_xfer;

    assign in_xfer  = rev_valid && rev_ready;
    assign out_xfer = out_valid && out_ready;

    // The head slot drives the output, the skid slot catches what the head cannot take.
    always_comb begin
        head_n   = out_beat;
        head_v_n = out_valid;
        skid_n   = skid_beat;
        skid_v_n = skid_valid;
        if (!out_valid || out_ready) begin
            if (skid_valid) begin
                head_n   = skid_beat;
                head_v_n = 1'b1;
                skid_n   = rev_beat;
                skid_v_n = in_xfer;
            end else begin
                head_n   = rev_beat;
                head_v_n = in_xfer;
            end
        end else if (in_xfer) begin
            skid_n   = rev_beat;
            skid_v_n = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid  <= 1'b0;
            skid_valid <= 1'b0;
            rev_ready  <= 1'b1;
            line_count <= '0;
        end else begin
            out_valid  <= head_v_n;
            skid_valid <= skid_v_n;
            rev_ready  <= !(head_v_n && skid_v_n);
            if (out_xfer && out_beat.last) begin
                line_count <= line_count + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        out_beat  <= head_n;
        skid_beat <= skid_n;
    end

endmodule

/* verilog/line_mirror_top.sv */
`timescale 1ns/1ps
`include "line_mirror_config.svh"

module line_mirror_top (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [`LM_PIX_W-1:0]         pix_in,
    input  logic                         pix_in_en,
    input  logic [`LM_ADDR_W:0]          width,
    input  line_mirror_pkg::byte_order_e order,
    input  logic                         out_ready,
    output line_mirror_pkg::pixel_beat_t out_beat,
    output logic                         out_valid,
    output logic [15:0]                  line_count,
    output logic                         overflow
);

    line_mirror_pkg::pixel_beat_t in_beat;
    line_mirror_pkg::pixel_beat_t rev_beat;
    logic                         in_en;
    logic                         rev_valid;
    logic                         rev_ready;

    pixel_ingress u_ingress (
        .clk       (clk),
        .rst       (rst),
        .pix_in    (pix_in),
        .pix_in_en (pix_in_en),
        .width     (width),
        .order     (order),
        .in_beat   (in_beat),
        .in_en     (in_en)
    );

    line_reverse u_reverse (
        .clk       (clk),
        .rst       (rst),
        .in_beat   (in_beat),
        .in_en     (in_en),
        .rev_beat  (rev_beat),
        .rev_valid (rev_valid),
        .rev_ready (rev_ready),
        .overflow  (overflow)
    );

    pixel_egress u_egress (
        .clk        (clk),
        .rst        (rst),
        .rev_beat   (rev_beat),
        .rev_valid  (rev_valid),
        .rev_ready  (rev_ready),
        .out_beat   (out_beat),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .line_count (line_count)
    );

endmodule

/* sim/line_mirror_asserts.sv */
`timescale 1ns/1ps

module line_mirror_asserts #(
    parameter bit HAS_HALVES = 1'b1
) (
    input logic                         clk,
    input logic                         rst,
    input line_mirror_pkg::pixel_beat_t beat,
    input logic                         valid,
    input logic                         ready,
    input line_mirror_pkg::buf_state_e  state0,
    input line_mirror_pkg::buf_state_e  state1,
    input logic                         overflow
);

    // Number of assertion failures seen so far.
    int errors = 0;

    hold_beat: assert property (@(posedge clk) disable iff (rst)
        valid && !ready |=> valid && $stable(beat))
    else begin
        $error("Beat changed or valid dropped while the receiver stalled.");
        errors++;
    end

    // Buffer checks only apply where the ping-pong halves exist.
    if (HAS_HALVES) begin : g_halves

        one_draining: assert property (@(posedge clk) disable iff (rst)
            !(state0 == line_mirror_pkg::BUF_DRAINING &&
              state1 == line_mirror_pkg::BUF_DRAINING))
        else begin
            $error("Both buffer halves are draining.");
            errors++;
        end

        sticky_overflow: assert property (@(posedge clk) disable iff (rst)
            $fell(overflow) |-> $past(rst))
        else begin
            $error("Overflow fell without a reset.");
            errors++;
        end

    end

endmodule

bind line_reverse line_mirror_asserts #(.HAS_HALVES(1'b1)) rev_chk (
    .clk      (clk),
    .rst      (rst),
    .beat     (rev_beat),
    .valid    (rev_valid),
    .ready    (rev_ready),
    .state0   (state[0]),
    .state1   (state[1]),
    .overflow (overflow)
);

bind pixel_egress line_mirror_asserts #(.HAS_HALVES(1'b0)) egr_chk (
    .clk      (clk),
    .rst      (rst),
    .beat     (out_beat),
    .valid    (out_valid),
    .ready    (out_ready),
    .state0   (line_mirror_pkg::BUF_EMPTY),
    .state1   (line_mirror_pkg::BUF_EMPTY),
    .overflow (1'b0)
);

/* sim/line_mirror_tb.sv */
`timescale 1ns/1ps
`include "line_mirror_config.svh"

module line_mirror_tb;

    localparam int NUM_ROWS = 9;
    localparam int TIMEOUT  = 5000;

    // Stall 0 keeps out_ready high, 1 draws it at random, 2 holds it low until input ends.
    typedef struct {
        int                           width_a;
        int                           width_b;
        line_mirror_pkg::byte_order_e order;
        int                           gap;
        int                           lines;
        int                           stall;
        bit                           exp_ovf;
    } row_t;

    logic                         clk = 1'b0;
    logic                         rst;
    logic [`LM_PIX_W-1:0]         pix_in;
    logic                         pix_in_en;
    logic [`LM_ADDR_W:0]          width;
    line_mirror_pkg::byte_order_e order;
    logic                         out_ready;
    line_mirror_pkg::pixel_beat_t out_beat;
    logic                         out_valid;
    logic [15:0]                  line_count;
    logic                         overflow;

    row_t                         rows [NUM_ROWS];
    line_mirror_pkg::pixel_beat_t exp_q [$];
    logic                         input_done;
    integer                       seed = 32'hbb29;

    line_mirror_top DUT (
        .clk        (clk),
        .rst        (rst),
        .pix_in     (pix_in),
        .pix_in_en  (pix_in_en),
        .width      (width),
        .order      (order),
        .out_ready  (out_ready),
        .out_beat   (out_beat),
        .out_valid  (out_valid),
        .line_count (line_count),
        .overflow   (overflow)
    );

    always #10 clk = ~clk;

    task automatic stop_with_failure();
        $display(">>> FAIL");
        $fatal(1, "Simulation stopped at the first failure.");
    endtask

    function automatic logic [`LM_PIX_W-1:0] order_bytes(input logic [`LM_PIX_W-1:0] pix,
                                                         input line_mirror_pkg::byte_order_e ord);
        logic [`LM_PIX_W-1:0] res;
        int                   k;
        int                   src;
        for (k = 0; k < 4; k++) begin
            if (ord == line_mirror_pkg::ORDER_SWAP16) begin
                src = k ^ 1;
            end else if (ord == line_mirror_pkg::ORDER_SWAP32) begin
                src = 3 - k;
            end else begin
                src = k;
            end
            res[8*k +: 8] = pix[8*src +: 8];
        end
        return res;
    endfunction

    task automatic check_beat(input line_mirror_pkg::pixel_beat_t got,
                              input line_mirror_pkg::pixel_beat_t exp);
        if (got !== exp) begin
            $display("Error at %0t: beat data %h last %b, expected data %h last %b",
                     $time, got.data, got.last, exp.data, exp.last);
            stop_with_failure();
        end
    endtask

    task automatic check_count(input logic [15:0] got_count, input logic got_ovf,
                               input logic [15:0] exp_count, input logic exp_ovf);
        if (got_count !== exp_count || got_ovf !== exp_ovf) begin
            $display("Error at %0t: line_count %0d overflow %b, expected %0d and %b",
                     $time, got_count, got_ovf, exp_count, exp_ovf);
            stop_with_failure();
        end
    endtask

    // Lines alternate between the two widths of a row. Dropped lines add nothing to the model.
    task automatic drive_row(input row_t row);
        logic [`LM_PIX_W-1:0]         pix [$];
        line_mirror_pkg::pixel_beat_t b;
        int                           n;
        int                           i;
        int                           w;
        for (n = 0; n < row.lines; n++) begin
            w = (n % 2 == 0) ? row.width_a : row.width_b;
            pix.delete();
            for (i = 0; i < w; i++) begin
                pix.push_back($random(seed));
            end
            if (!(row.exp_ovf && n >= 2)) begin
                for (i = w - 1; i >= 0; i--) begin
                    b.data = order_bytes(pix[i], row.order);
                    b.last = (i == 0);
                    exp_q.push_back(b);
                end
            end
            for (i = 0; i < w; i++) begin
                @(posedge clk);
                pix_in    <= pix[i];
                pix_in_en <= 1'b1;
                width     <= w[`LM_ADDR_W:0];
                order     <= row.order;
                repeat (row.gap) begin
                    @(posedge clk);
                    pix_in_en <= 1'b0;
                end
            end
        end
        @(posedge clk);
        pix_in_en  <= 1'b0;
        input_done <= 1'b1;
    endtask

    task automatic collect_row(input int stall, input int n_beats);
        int          got;
        int          idle;
        logic [31:0] r;
        got  = 0;
        idle = 0;
        while (got < n_beats) begin
            @(posedge clk);
            if (out_valid && out_ready) begin
                if (exp_q.size() == 0) begin
                    $display("Error at %0t: output beat with no beat expected", $time);
                    stop_with_failure();
                end
                check_beat(out_beat, exp_q.pop_front());
                got++;
                idle = 0;
            end else if (idle == TIMEOUT) begin
                $display("Timeout: no output beat for %0d cycles at %0t.", TIMEOUT, $time);
                stop_with_failure();
            end else begin
                idle++;
            end
            if (stall == 1) begin
                r = $random(seed);
                out_ready <= r[0];
            end else if (stall == 2) begin
                out_ready <= input_done;
            end else begin
                out_ready <= 1'b1;
            end
        end
        out_ready <= 1'b1;
    endtask

    // Once a row is complete the output must stay idle.
    task automatic check_idle();
        repeat (20) begin
            @(posedge clk);
            if (out_valid) begin
                $display("Error at %0t: unexpected extra output beat", $time);
                stop_with_failure();
            end
        end
    endtask

    always @(negedge clk) begin
        if (DUT.u_reverse.rev_chk.errors != 0 || DUT.u_egress.egr_chk.errors != 0) begin
            $display("A bound assertion failed at %0t.", $time);
            stop_with_failure();
        end
    end

    initial begin
        int          r;
        int          n;
        int          n_beats;
        logic [15:0] exp_lines;
        logic        exp_ovf;
        rows[0] = '{1, 1, line_mirror_pkg::ORDER_KEEP, 2, 1, 0, 1'b0};
        rows[1] = '{5, 5, line_mirror_pkg::ORDER_KEEP, 1, 1, 0, 1'b0};
        rows[2] = '{64, 64, line_mirror_pkg::ORDER_KEEP, 0, 1, 0, 1'b0};
        rows[3] = '{8, 8, line_mirror_pkg::ORDER_SWAP16, 1, 2, 0, 1'b0};
        rows[4] = '{8, 8, line_mirror_pkg::ORDER_SWAP32, 0, 2, 0, 1'b0};
        rows[5] = '{9, 4, line_mirror_pkg::ORDER_KEEP, 0, 2, 0, 1'b0};
        rows[6] = '{3, 17, line_mirror_pkg::ORDER_SWAP32, 0, 2, 0, 1'b0};
        rows[7] = '{64, 48, line_mirror_pkg::ORDER_SWAP16, 0, 2, 1, 1'b0};
        rows[8] = '{16, 16, line_mirror_pkg::ORDER_KEEP, 0, 3, 2, 1'b1};
        rst        = 1'b1;
        pix_in     = '0;
        pix_in_en  = 1'b0;
        width      = '0;
        order      = line_mirror_pkg::ORDER_KEEP;
        out_ready  = 1'b1;
        input_done = 1'b0;
        exp_lines  = '0;
        exp_ovf    = 1'b0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        for (r = 0; r < NUM_ROWS; r++) begin
            n_beats = 0;
            for (n = 0; n < rows[r].lines; n++) begin
                if (!(rows[r].exp_ovf && n >= 2)) begin
                    n_beats   += (n % 2 == 0) ? rows[r].width_a : rows[r].width_b;
                    exp_lines += 1'b1;
                end
            end
            exp_ovf    = exp_ovf | rows[r].exp_ovf;
            input_done = 1'b0;
            fork
                drive_row(rows[r]);
                collect_row(rows[r].stall, n_beats);
            join
            check_idle();
            check_count(line_count, overflow, exp_lines, exp_ovf);
        end
        if (DUT.u_reverse.rev_chk.errors + DUT.u_egress.egr_chk.errors != 0) begin
            $display("Bound assertions reported failures during the run.");
            stop_with_failure();
        end else begin
            $display(">>> PASS");
            $finish;
        end
    end

endmodule

/* vlog.f */
+incdir+common
common/line_mirror_pkg.sv
verilog/pixel_ingress.sv
line_reverse/line_reverse.sv
verilog/pixel_egress.sv
verilog/line_mirror_top.sv
sim/line_mirror_asserts.sv
sim/line_mirror_tb.sv
